// File: verilog.f
rtl/tv_pkg.sv
rtl/vram_if.sv
rtl/frame_tick_timer.sv
rtl/vram_access_fsm.sv
rtl/tv_ctrl_regs.sv
rtl/vram_store.sv
rtl/xbus_tv_top.sv
+incdir+verif
verif/tv_tb.sv

// File: verif/tv_tb_checks.svh
// Typed compare tasks and bus transaction tasks, included inside the testbench top module
`ifndef TV_TB_CHECKS_SVH
`define TV_TB_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// Compares

task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
   if (act !== exp)
      report_failure($sformatf("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp)
      report_failure($sformatf("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act));
endtask

//////////////////////////////////////////////////////////////////////
// Bus cycles

// One full master cycle, ack must show up exactly lat edges after req
task automatic bus_cycle(input logic wr, input bus_addr_t a, input bus_data_t d,
                         input int lat, output bus_data_t rd);
   @(posedge clk);
   #0.5;
   addr   = a;
   datain = d;
   write  = wr;
   req    = 1'b1;
   for (int n = 1; n <= lat; n++) begin
      @(posedge clk);
      #1;
      check_bit("ack", n == lat, ack);
   end
   // Read data must already sit on dataout with the first ack
   rd = dataout;
   @(posedge clk);
   #0.5;
   req = 1'b0;
   // DONE falls back to IDLE on the edge that sees req low
   @(posedge clk);
   #1;
   check_bit("ack", 1'b0, ack);
endtask

// Poll for the interrupt level within a cycle budget
task automatic wait_interrupt(input int limit);
   int n;
   n = 0;
   while (!interrupt && n < limit) begin
      @(posedge clk);
      #1;
      n++;
   end
   if (!interrupt)
      report_failure($sformatf("interrupt did not rise within %0d cycles", limit));
endtask

`endif

// File: verif/tv_tb.sv
// Testbench top that drives the display-memory slave through its stimulus table and interrupt checks
`timescale 1ns/10ps

module tv_tb import tv_pkg::*; ();

   localparam int TICK_CYCLES  = 200;
   localparam int READ_LAT     = 3;
   localparam int WRITE_LAT    = 2;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_ROWS     = 20;
   localparam int CYCLE_LIMIT  = NUM_ROWS * (READ_LAT + 6) + 4 * TICK_CYCLES + RESET_CYCLES;

   // Control/status register address and bit values
   localparam bus_addr_t CSR  = 22'o17377760;
   localparam bus_data_t EN   = 32'h8;
   localparam bus_data_t FLAG = 32'h10;

   typedef struct {
      logic      wr;
      bus_addr_t addr;
      bus_data_t data;
      bus_data_t exp;
      // Mask of the bits compared on readback
      bus_data_t mask;
      int        lat;
   } row_t;

   logic      clk;
   logic      reset;
   bus_addr_t addr;
   bus_data_t datain;
   logic      req;
   logic      write;
   bus_data_t dataout;
   logic      ack;
   logic      decode;
   logic      interrupt;
   row_t      rows [NUM_ROWS];
   int        cycle_count;

   xbus_tv_top #(
      .TICK_CYCLES (TICK_CYCLES),
      .READ_LAT    (READ_LAT),
      .WRITE_LAT   (WRITE_LAT)
   ) u_dut (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .datain    (datain),
      .req       (req),
      .write     (write),
      .dataout   (dataout),
      .ack       (ack),
      .decode    (decode),
      .interrupt (interrupt)
   );

   task automatic report_failure(input string line);
      $display("%s", line);
      $display(">>> FAIL");
      $fatal(1, "run stopped");
   endtask

   `include "tv_tb_checks.svh"

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Run length guard
   initial cycle_count = 0;
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT)
         report_failure("timeout, the run did not finish within its cycle budget");
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus table of frame-buffer writes and reads and CSR pairs

   task automatic build_table();
      vram_addr_t offs [8];
      offs = '{15'o00000, 15'o77777, 15'o00001, 15'o12345,
               15'o40000, 15'o00777, 15'o52525, 15'o70001};
      for (int i = 0; i < 8; i++) begin
         rows[i]     = '{1'b1, {7'o170, offs[i]}, $urandom, '0, '0, WRITE_LAT + 2};
         rows[i + 8] = '{1'b0, {7'o170, offs[i]}, '0, rows[i].data, '1, READ_LAT + 2};
      end
      rows[16] = '{1'b1, CSR, EN, '0, '0, 2};
      rows[17] = '{1'b0, CSR, '0, EN, ~FLAG, 2};
      rows[18] = '{1'b1, CSR + 22'd3, '0, '0, '0, 2};
      rows[19] = '{1'b0, CSR + 22'd7, '0, '0, ~FLAG, 2};
   endtask

   task automatic check_decode(input bus_addr_t a, input logic exp);
      @(posedge clk);
      #0.5;
      addr = a;
      #0.5;
      check_bit("decode", exp, decode);
   endtask

   initial begin
      bus_data_t rd;
      void'($urandom(32'hbe03));
      reset  = 1'b1;
      addr   = '0;
      datain = '0;
      req    = 1'b0;
      write  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #0.5;
      reset = 1'b0;
      #0.5;
      // Quiet outputs out of reset
      check_bit("ack", 1'b0, ack);
      check_bit("interrupt", 1'b0, interrupt);
      check_data("dataout", '0, dataout);

      build_table();
      for (int i = 0; i < NUM_ROWS; i++) begin
         bus_cycle(rows[i].wr, rows[i].addr, rows[i].data, rows[i].lat, rd);
         if (!rows[i].wr)
            check_data("dataout", rows[i].exp & rows[i].mask, rd & rows[i].mask);
      end

      // Region edges
      check_decode(22'o17000000, 1'b1);
      check_decode(22'o17077777, 1'b1);
      check_decode(22'o16777777, 1'b0);
      check_decode(22'o17100000, 1'b0);
      check_decode(22'o17377760, 1'b1);
      check_decode(22'o17377767, 1'b1);
      check_decode(22'o17377757, 1'b0);
      check_decode(22'o17377770, 1'b0);

      // Unmapped request stays unanswered
      @(posedge clk);
      #0.5;
      addr  = 22'o17100000;
      write = 1'b0;
      req   = 1'b1;
      repeat (20) begin
         @(posedge clk);
         #1;
         check_bit("ack", 1'b0, ack);
      end
      @(posedge clk);
      #0.5;
      req = 1'b0;

      // Enable on and stale flag cleared
      bus_cycle(1'b1, CSR, EN | FLAG, 2, rd);
      wait_interrupt(TICK_CYCLES + 2);
      bus_cycle(1'b1, CSR, EN | FLAG, 2, rd);
      check_bit("interrupt", 1'b0, interrupt);
      wait_interrupt(TICK_CYCLES + 2);

      // Enable off while the flag still sets on the next frame
      bus_cycle(1'b1, CSR, FLAG, 2, rd);
      repeat (TICK_CYCLES + 2) begin
         @(posedge clk);
         #1;
         check_bit("interrupt", 1'b0, interrupt);
      end
      bus_cycle(1'b0, CSR, '0, 2, rd);
      check_data("dataout", FLAG, rd);

      $display(">>> PASS");
      $finish;
   end

endmodule

// File: rtl/xbus_tv_top.sv
// Top of the display-memory slave, joins timer, sequencer, registers and VRAM to the bus ports
`timescale 1ns/10ps

module xbus_tv_top #(
   parameter int TICK_CYCLES = 200,
   parameter int READ_LAT    = 3,
   parameter int WRITE_LAT   = 2
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   input  logic        req,
   input  logic        write,
   output logic [31:0] dataout,
   output logic        ack,
   output logic        decode,
   output logic        interrupt
);

   logic tick;
   logic reg_wr;
   logic reg_rd;

   // Sequencer to memory bundle
   vram_if vram_bus ();

   ////////////////////////////////////////////////////////////////////
   // Frame source

   frame_tick_timer #(
      .TICK_CYCLES (TICK_CYCLES)
   ) u_timer (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   ////////////////////////////////////////////////////////////////////
   // Decode and sequencing

   vram_access_fsm u_fsm (
      .clk    (clk),
      .reset  (reset),
      .addr   (addr),
      .datain (datain),
      .req    (req),
      .write  (write),
      .decode (decode),
      .ack    (ack),
      .reg_wr (reg_wr),
      .reg_rd (reg_rd),
      .vram   (vram_bus.master)
   );

   // Interrupt logic and read return
   tv_ctrl_regs u_regs (
      .clk       (clk),
      .reset     (reset),
      .datain    (datain),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .tick      (tick),
      .vram      (vram_bus.monitor),
      .dataout   (dataout),
      .interrupt (interrupt)
   );

   ////////////////////////////////////////////////////////////////////
   // Display memory

   vram_store #(
      .READ_LAT  (READ_LAT),
      .WRITE_LAT (WRITE_LAT)
   ) u_vram (
      .clk   (clk),
      .reset (reset),
      .vram  (vram_bus.mem)
   );

endmodule

// File: rtl/vram_store.sv
// Behavioural display memory with fixed read and write latencies and completion pulses
`timescale 1ns/10ps

module vram_store import tv_pkg::*; #(
   parameter int READ_LAT  = 3,
   parameter int WRITE_LAT = 2
) (
   input  logic clk,
   input  logic reset,
   vram_if.mem  vram
);

   localparam int MAX_LAT = (READ_LAT > WRITE_LAT) ? READ_LAT : WRITE_LAT;
   localparam int CNT_W   = $clog2(MAX_LAT + 1);
   localparam logic [CNT_W-1:0] RD_LAST = CNT_W'(READ_LAT - 1);
   localparam logic [CNT_W-1:0] WR_LAST = CNT_W'(WRITE_LAT - 1);

   bus_data_t mem [32768];

   logic [CNT_W-1:0] lat_cnt;
   // Access already completed, wait for the level to drop
   logic served;
   logic active;
   logic last;
   logic finish;

   assign active = vram.req | vram.write;
   assign last   = vram.write ? (lat_cnt == WR_LAST) : (lat_cnt == RD_LAST);
   assign finish = active && !served && last;

   ////////////////////////////////////////////////////////////////////
   // Latency counter and completion pulses

   always_ff @(posedge clk) begin
      if (reset) begin
         lat_cnt    <= '0;
         served     <= 1'b0;
         vram.done  <= 1'b0;
         vram.ready <= 1'b0;
      end else begin
         vram.done  <= finish && vram.write;
         vram.ready <= finish && !vram.write;
         if (!active) begin
            // Idle, rearm for the next rise
            lat_cnt <= '0;
            served  <= 1'b0;
         end else if (finish) begin
            lat_cnt <= '0;
            served  <= 1'b1;
         end else if (!served) begin
            lat_cnt <= lat_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Storage

   always_ff @(posedge clk) begin
      if (finish && vram.write)
         mem[vram.addr] <= vram.wdata;
      if (finish && !vram.write)
         vram.rdata <= mem[vram.addr];
   end

   // Address must not move under an access
   a_addr_stable : assert property (
      @(posedge clk) disable iff (reset)
      active && $past(active) |-> $stable(vram.addr)
   ) else $error("VRAM address changed during an access");

endmodule

// File: rtl/tv_ctrl_regs.sv
// Interrupt enable and flag, interrupt output and the read-data return register of the slave
`timescale 1ns/10ps

module tv_ctrl_regs import tv_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  bus_data_t datain,
   input  logic      reg_wr,
   input  logic      reg_rd,
   input  logic      tick,
   vram_if.monitor   vram,
   output bus_data_t dataout,
   output logic      interrupt
);

   logic      int_en;
   logic      int_flag;
   bus_data_t csr_word;

   ////////////////////////////////////////////////////////////////////
   // Enable and flag

   always_ff @(posedge clk) begin
      if (reset) begin
         int_en   <= 1'b0;
         int_flag <= 1'b0;
      end else begin
         if (reg_wr)
            int_en <= datain[INT_EN_BIT];
         // Frame tick wins over a clear in the same cycle
         if (tick)
            int_flag <= 1'b1;
         else if (reg_wr && datain[INT_FLAG_BIT])
            int_flag <= 1'b0;
      end
   end

   assign interrupt = int_en & int_flag;

   ////////////////////////////////////////////////////////////////////
   // Read return

   // Status word, everything but the two bits reads zero
   always_comb begin
      csr_word               = '0;
      csr_word[INT_EN_BIT]   = int_en;
      csr_word[INT_FLAG_BIT] = int_flag;
   end

   always_ff @(posedge clk) begin
      if (reset)
         dataout <= '0;
      else if (reg_rd)
         dataout <= csr_word;
      else if (vram.ready)
         // Frame-buffer read data
         dataout <= vram.rdata;
   end

   // A register read and a VRAM read never finish in the same cycle
   a_rd_sources_exclusive : assert property (
      @(posedge clk) disable iff (reset) !(reg_rd && vram.ready)
   ) else $error("register read collided with VRAM ready");

endmodule

// File: rtl/vram_access_fsm.sv
// Bus decode and access sequencer that runs VRAM and register cycles and returns the acknowledge
`timescale 1ns/10ps

module vram_access_fsm import tv_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  bus_addr_t addr,
   input  bus_data_t datain,
   input  logic      req,
   input  logic      write,
   output logic      decode,
   output logic      ack,
   output logic      reg_wr,
   output logic      reg_rd,
   vram_if.master    vram
);

   access_state_t state;
   access_state_t state_ns;

   logic in_fb;
   logic in_reg;
   logic start;

   ////////////////////////////////////////////////////////////////////
   // Address decode

   assign in_fb  = addr[21:15] == FB_BASE_HI;
   assign in_reg = addr[21:3] == REG_BASE_HI;
   assign decode = in_fb | in_reg;

   // Only mapped requests leave IDLE
   assign start = (state == IDLE) && req && decode;

   // Register strobes, taken on the IDLE to REG edge
   assign reg_wr = start && in_reg && write;
   assign reg_rd = start && in_reg && !write;

   ////////////////////////////////////////////////////////////////////
   // Sequencer

   always_comb begin
      state_ns = state;
      case (state)
         IDLE: begin
            if (start) begin
               if (in_reg)
                  state_ns = REG;
               else if (write)
                  state_ns = WRITE;
               else
                  state_ns = READ;
            end
         end
         // Wait for the memory to finish
         WRITE: if (vram.done) state_ns = DONE;
         READ:  if (vram.ready) state_ns = DONE;
         // Register cycle is fixed length
         REG:   state_ns = DONE;
         // Hold ack until the master lets go
         DONE:  if (!req) state_ns = IDLE;
         default: state_ns = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= IDLE;
      else
         state <= state_ns;
   end

   assign ack = state == DONE;

   // VRAM side, levels follow the state
   assign vram.addr  = addr[14:0];
   assign vram.wdata = datain;
   assign vram.req   = state == READ;
   assign vram.write = state == WRITE;

   ////////////////////////////////////////////////////////////////////
   // Checks

   // Ack only comes out of a real access cycle
   a_ack_after_access : assert property (
      @(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(state) inside {WRITE, READ, REG}
   ) else $error("ack raised without an access cycle");

   a_vram_onehot : assert property (
      @(posedge clk) disable iff (reset) !(vram.req && vram.write)
   ) else $error("VRAM read and write requested together");

   // Unmapped requests stay in IDLE
   a_idle_needs_decode : assert property (
      @(posedge clk) disable iff (reset)
      (state == IDLE) && !decode |=> state == IDLE
   ) else $error("access started on an unmapped address");

endmodule

// File: rtl/frame_tick_timer.sv
// Frame period source that stands in for the 60 Hz tick and feeds the interrupt flag
`timescale 1ns/10ps

module frame_tick_timer #(
   parameter int TICK_CYCLES = 200
) (
   input  logic clk,
   input  logic reset,
   output logic tick
);

   localparam int CNT_W = $clog2(TICK_CYCLES + 1);
   localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_CYCLES - 1);

   logic [CNT_W-1:0] count;

   ////////////////////////////////////////////////////////////////////
   // Down counter, one tick per wrap

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= RELOAD;
         tick  <= 1'b0;
      end else if (count == '0) begin
         // Wrap and fire
         count <= RELOAD;
         tick  <= 1'b1;
      end else begin
         count <= count - 1'b1;
         tick  <= 1'b0;
      end
   end

   // Single-cycle pulse per frame
   a_tick_single : assert property (
      @(posedge clk) disable iff (reset) tick |=> !tick
   ) else $error("frame tick held for more than one cycle");

endmodule

// File: rtl/vram_if.sv
// Bundle between the access sequencer and the display memory, with a read-only tap
`timescale 1ns/10ps

interface vram_if import tv_pkg::*;;

   // Word offset into the frame buffer
   vram_addr_t addr;
   bus_data_t  wdata;
   bus_data_t  rdata;

   // Read request, level held until ready
   logic req;
   // Write request, level held until done
   logic write;
   // One-cycle completion pulses
   logic done;
   logic ready;

   // Sequencer side
   modport master (output addr, wdata, req, write, input rdata, done, ready);

   // Memory side
   modport mem (input addr, wdata, req, write, output rdata, done, ready);

   // Read data tap for the register block
   modport monitor (input rdata, ready);

endinterface

// File: rtl/tv_pkg.sv
// Shared types, address map and register layout for the display-memory slave, imported by RTL
package tv_pkg;

   ////////////////////////////////////////////////////////////////////
   // Widths

   // Extended bus word address
   typedef logic [21:0] bus_addr_t;

   // Bus and VRAM data word
   typedef logic [31:0] bus_data_t;

   // Frame-buffer word offset, 32K words
   typedef logic [14:0] vram_addr_t;

   ////////////////////////////////////////////////////////////////////
   // Address map

   // Frame buffer 17000000..17077777, match on addr[21:15]
   localparam logic [6:0]  FB_BASE_HI  = 7'o170;

   // Control/status block 17377760..17377767, match on addr[21:3]
   localparam logic [18:0] REG_BASE_HI = 19'o1737776;

   ////////////////////////////////////////////////////////////////////
   // Control/status register bits

   // Interrupt enable, read/write
   localparam int INT_EN_BIT   = 3;

   // Interrupt flag, read; write one to clear
   localparam int INT_FLAG_BIT = 4;

   ////////////////////////////////////////////////////////////////////
   // Access sequencer

   typedef enum logic [2:0] {
      IDLE,
      WRITE,
      READ,
      REG,
      DONE
   } access_state_t;

endpackage
